// File: Bender.yml
package:
  name: core_bus

export_include_dirs:
  - src

sources:
  - src/axi_pkg.sv
  - src/bus_pkg.sv
  - src/dev_bus_if.sv
  - src/bus_arbiter.sv
  - src/uart_tx_buffer.sv
  - src/clint_timer.sv
  - src/core_bus_top.sv
  - target: test
    files:
      - verif/axi_mem_model.sv
      - verif/tb_core_bus_top.sv

// File: flist.f
+incdir+src
src/axi_pkg.sv
src/bus_pkg.sv
src/dev_bus_if.sv
src/bus_arbiter.sv
src/uart_tx_buffer.sv
src/clint_timer.sv
src/core_bus_top.sv
verif/axi_mem_model.sv
verif/tb_core_bus_top.sv

// File: src/axi_pkg.sv
package axi_pkg;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // bytes per beat as log2
  typedef enum logic [2:0] {
    SIZE_1B   = 3'd0,
    SIZE_2B   = 3'd1,
    SIZE_4B   = 3'd2,
    SIZE_8B   = 3'd3,
    SIZE_16B  = 3'd4,
    SIZE_32B  = 3'd5,
    SIZE_64B  = 3'd6,
    SIZE_128B = 3'd7
  } size_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

endpackage

// File: src/bus_arbiter.sv
`include "bus_cfg.svh"

module bus_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  // instruction fetch
  input  logic                   ifu_arvalid_i,
  input  logic [`BUS_ADDR_W-1:0] ifu_araddr_i,
  output logic [`BUS_DATA_W-1:0] ifu_rdata_o,
  output logic                   ifu_rvalid_o,
  // loads
  input  logic                   lsu_arvalid_i,
  input  logic [`BUS_ADDR_W-1:0] lsu_araddr_i,
  output logic [`BUS_DATA_W-1:0] lsu_rdata_o,
  output logic                   lsu_rvalid_o,
  // stores
  input  logic                   lsu_awvalid_i,
  input  logic [`BUS_ADDR_W-1:0] lsu_awaddr_i,
  input  logic [`BUS_DATA_W-1:0] lsu_wdata_i,
  input  logic [`AXI_STRB_W-1:0] lsu_wstrb_i,
  output logic                   lsu_wready_o,
  // AXI4 master
  output logic [`BUS_ADDR_W-1:0] m_axi_awaddr_o,
  output logic                   m_axi_awvalid_o,
  input  logic                   m_axi_awready_i,
  output logic [7:0]             m_axi_awlen_o,
  output axi_pkg::size_e         m_axi_awsize_o,
  output axi_pkg::burst_e        m_axi_awburst_o,
  output logic [3:0]             m_axi_awid_o,
  output logic [`AXI_DATA_W-1:0] m_axi_wdata_o,
  output logic [`AXI_STRB_W-1:0] m_axi_wstrb_o,
  output logic                   m_axi_wlast_o,
  output logic                   m_axi_wvalid_o,
  input  logic                   m_axi_wready_i,
  input  logic                   m_axi_bvalid_i,
  output logic                   m_axi_bready_o,
  output logic [`BUS_ADDR_W-1:0] m_axi_araddr_o,
  output logic                   m_axi_arvalid_o,
  input  logic                   m_axi_arready_i,
  output logic [7:0]             m_axi_arlen_o,
  output axi_pkg::size_e         m_axi_arsize_o,
  output axi_pkg::burst_e        m_axi_arburst_o,
  output logic [3:0]             m_axi_arid_o,
  input  logic [`AXI_DATA_W-1:0] m_axi_rdata_i,
  input  logic                   m_axi_rvalid_i,
  output logic                   m_axi_rready_o,
  // devices
  dev_wr_if.master               uart_wr,
  dev_rd_if.master               clint_rd
);

  typedef enum logic [2:0] {RD_IDLE, RD_AR, RD_R, RD_TREQ, RD_TWAIT} rd_state_e;
  typedef enum logic [1:0] {WR_IDLE, WR_MEM, WR_UART} wr_state_e;

  rd_state_e              rd_state;
  logic                   rd_lsu;
  logic [`BUS_ADDR_W-1:0] rd_addr;
  bus_pkg::dev_sel_e      lsu_rd_sel;

  wr_state_e              wr_state;
  logic                   aw_pend;
  logic                   w_pend;
  logic [`BUS_ADDR_W-1:0] wr_addr;
  logic [`BUS_DATA_W-1:0] wr_data;
  logic [`AXI_STRB_W-1:0] wr_strb;
  bus_pkg::dev_sel_e      wr_sel;
  axi_pkg::size_e         wr_size;

  assign lsu_rd_sel = bus_pkg::decode_sel(lsu_araddr_i);
  assign wr_sel     = bus_pkg::decode_sel(lsu_awaddr_i);

  // read side, load wins over fetch
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_state <= RD_IDLE;
      rd_lsu   <= 1'b0;
    end
    else
    begin
      case (rd_state)
        RD_IDLE:
          if (lsu_arvalid_i)
          begin
            rd_lsu   <= 1'b1;
            rd_state <= (lsu_rd_sel == bus_pkg::DEV_TIMER) ? RD_TREQ : RD_AR;
          end
          else if (ifu_arvalid_i)
          begin
            rd_lsu   <= 1'b0;
            rd_state <= RD_AR;
          end
        RD_AR:
          if (m_axi_arready_i)
            rd_state <= RD_R;
        RD_R:
          if (m_axi_rvalid_i)
            rd_state <= RD_IDLE;
        RD_TREQ:
          rd_state <= RD_TWAIT;
        RD_TWAIT:
          if (clint_rd.rvalid)
            rd_state <= RD_IDLE;
        default:
          rd_state <= RD_IDLE;
      endcase
    end
  end

  // address latched together with the owner
  always_ff @(posedge clk)
  begin
    if (rd_state == RD_IDLE)
      rd_addr <= lsu_arvalid_i ? lsu_araddr_i : ifu_araddr_i;
  end

  assign m_axi_araddr_o  = rd_addr;
  assign m_axi_arvalid_o = (rd_state == RD_AR);
  assign m_axi_arlen_o   = 8'd0;
  assign m_axi_arsize_o  = axi_pkg::SIZE_4B;
  assign m_axi_arburst_o = axi_pkg::BURST_INCR;
  assign m_axi_arid_o    = 4'd0;
  assign m_axi_rready_o  = 1'b1;

  assign clint_rd.arvalid = (rd_state == RD_TREQ);
  assign clint_rd.sel_hi  = (rd_addr == `BUS_RTC_ADDR_UP);

  assign ifu_rdata_o  = m_axi_rdata_i[`BUS_DATA_W-1:0];
  assign ifu_rvalid_o = (rd_state == RD_R) && !rd_lsu && m_axi_rvalid_i;
  assign lsu_rdata_o  = (rd_state == RD_TWAIT) ? clint_rd.rdata
                                               : m_axi_rdata_i[`BUS_DATA_W-1:0];
  assign lsu_rvalid_o = ((rd_state == RD_R) && rd_lsu && m_axi_rvalid_i) ||
                        ((rd_state == RD_TWAIT) && clint_rd.rvalid);

  // write side, aw and w retire independently, b closes the store
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_state <= WR_IDLE;
      aw_pend  <= 1'b0;
      w_pend   <= 1'b0;
    end
    else
    begin
      case (wr_state)
        WR_IDLE:
          if (lsu_awvalid_i)
          begin
            if (wr_sel == bus_pkg::DEV_SERIAL)
              wr_state <= WR_UART;
            else
            begin
              wr_state <= WR_MEM;
              aw_pend  <= 1'b1;
              w_pend   <= 1'b1;
            end
          end
        WR_MEM:
        begin
          if (m_axi_awready_i)
            aw_pend <= 1'b0;
          if (m_axi_wready_i)
            w_pend <= 1'b0;
          if (m_axi_bvalid_i)
            wr_state <= WR_IDLE;
        end
        WR_UART:
          if (uart_wr.wready)
            wr_state <= WR_IDLE;
        default:
          wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((wr_state == WR_IDLE) && lsu_awvalid_i)
    begin
      wr_addr <= lsu_awaddr_i;
      wr_data <= lsu_wdata_i;
      wr_strb <= lsu_wstrb_i;
    end
  end

  // transfer size from the number of enabled byte lanes
  always_comb
  begin
    case ($countones(wr_strb))
      1:       wr_size = axi_pkg::SIZE_1B;
      2:       wr_size = axi_pkg::SIZE_2B;
      default: wr_size = axi_pkg::SIZE_4B;
    endcase
  end

  assign m_axi_awaddr_o  = wr_addr;
  assign m_axi_awvalid_o = (wr_state == WR_MEM) && aw_pend;
  assign m_axi_awlen_o   = 8'd0;
  assign m_axi_awsize_o  = wr_size;
  assign m_axi_awburst_o = axi_pkg::BURST_INCR;
  assign m_axi_awid_o    = 4'd0;
  assign m_axi_wdata_o   = {{(`AXI_DATA_W - `BUS_DATA_W){1'b0}}, wr_data};
  assign m_axi_wstrb_o   = wr_strb;
  assign m_axi_wlast_o   = 1'b1;
  assign m_axi_wvalid_o  = (wr_state == WR_MEM) && w_pend;
  assign m_axi_bready_o  = 1'b1;

  assign uart_wr.wvalid = (wr_state == WR_UART);
  assign uart_wr.wdata  = wr_data[7:0];

  assign lsu_wready_o = ((wr_state == WR_MEM) && m_axi_bvalid_i) ||
                        ((wr_state == WR_UART) && uart_wr.wready);

  ar_hold: assert property (@(posedge clk) disable iff (rst)
    m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o));

  // one read response per cycle, to a requester still waiting for it
  rd_one_owner: assert property (@(posedge clk) disable iff (rst)
    !(ifu_rvalid_o && lsu_rvalid_o) && (!ifu_rvalid_o || ifu_arvalid_i) &&
    (!lsu_rvalid_o || lsu_arvalid_i));

endmodule

// File: src/bus_cfg.svh
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// core-side bus widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// AXI4 master widths, only the low data word is used
`define AXI_DATA_W 64
`define AXI_STRB_W 8

// address map
`define BUS_SERIAL_ADDR 32'ha000_03f8
`define BUS_RTC_ADDR 32'ha000_0048
`define BUS_RTC_ADDR_UP 32'ha000_004c

// serial transmit buffer
`define UART_DEPTH 8
`define UART_DRAIN_CYCLES 4

`endif

// File: src/bus_pkg.sv
`include "bus_cfg.svh"

package bus_pkg;

  // target of a core-side access
  typedef enum logic [1:0] {
    DEV_MEM    = 2'd0,
    DEV_SERIAL = 2'd1,
    DEV_TIMER  = 2'd2
  } dev_sel_e;

  typedef struct packed {
    logic [`BUS_DATA_W-1:0] hi;
    logic [`BUS_DATA_W-1:0] lo;
  } mtime_half_t;

  // counter word, incremented as a whole and read back by halves
  typedef union packed {
    logic [2*`BUS_DATA_W-1:0] count;
    mtime_half_t              half;
  } mtime_u;

  function automatic dev_sel_e decode_sel(input logic [`BUS_ADDR_W-1:0] addr);
    if (addr == `BUS_SERIAL_ADDR)
      return DEV_SERIAL;
    if ((addr == `BUS_RTC_ADDR) || (addr == `BUS_RTC_ADDR_UP))
      return DEV_TIMER;
    return DEV_MEM;
  endfunction

endpackage

// File: src/clint_timer.sv
`include "bus_cfg.svh"

module clint_timer (
  input  logic    clk,
  input  logic    rst,
  dev_rd_if.slave rd
);

  bus_pkg::mtime_u        mtime;
  logic [`BUS_DATA_W-1:0] rdata_q;
  logic                   rvalid_q;

  // free-running machine time
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime.count <= '0;
    else
      mtime.count <= mtime.count + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rvalid_q <= 1'b0;
    else
      rvalid_q <= rd.arvalid;
  end

  // half selected at request time
  always_ff @(posedge clk)
  begin
    if (rd.arvalid)
      rdata_q <= rd.sel_hi ? mtime.half.hi : mtime.half.lo;
  end

  assign rd.rdata  = rdata_q;
  assign rd.rvalid = rvalid_q;

  // rvalid answers a single-cycle arvalid pulse
  rvalid_after_req: assert property (@(posedge clk) disable iff (rst)
    rd.rvalid |-> $past(rd.arvalid) && !rd.arvalid);

endmodule

// File: src/core_bus_top.sv
`include "bus_cfg.svh"

module core_bus_top (
  input  logic                   clk,
  input  logic                   rst,
  // instruction fetch
  input  logic                   ifu_arvalid_i,
  input  logic [`BUS_ADDR_W-1:0] ifu_araddr_i,
  output logic [`BUS_DATA_W-1:0] ifu_rdata_o,
  output logic                   ifu_rvalid_o,
  // loads
  input  logic                   lsu_arvalid_i,
  input  logic [`BUS_ADDR_W-1:0] lsu_araddr_i,
  output logic [`BUS_DATA_W-1:0] lsu_rdata_o,
  output logic                   lsu_rvalid_o,
  // stores
  input  logic                   lsu_awvalid_i,
  input  logic [`BUS_ADDR_W-1:0] lsu_awaddr_i,
  input  logic [`BUS_DATA_W-1:0] lsu_wdata_i,
  input  logic [`AXI_STRB_W-1:0] lsu_wstrb_i,
  output logic                   lsu_wready_o,
  // AXI4 master to main memory
  output logic [`BUS_ADDR_W-1:0] m_axi_awaddr_o,
  output logic                   m_axi_awvalid_o,
  input  logic                   m_axi_awready_i,
  output logic [7:0]             m_axi_awlen_o,
  output axi_pkg::size_e         m_axi_awsize_o,
  output axi_pkg::burst_e        m_axi_awburst_o,
  output logic [3:0]             m_axi_awid_o,
  output logic [`AXI_DATA_W-1:0] m_axi_wdata_o,
  output logic [`AXI_STRB_W-1:0] m_axi_wstrb_o,
  output logic                   m_axi_wlast_o,
  output logic                   m_axi_wvalid_o,
  input  logic                   m_axi_wready_i,
  input  logic                   m_axi_bvalid_i,
  output logic                   m_axi_bready_o,
  output logic [`BUS_ADDR_W-1:0] m_axi_araddr_o,
  output logic                   m_axi_arvalid_o,
  input  logic                   m_axi_arready_i,
  output logic [7:0]             m_axi_arlen_o,
  output axi_pkg::size_e         m_axi_arsize_o,
  output axi_pkg::burst_e        m_axi_arburst_o,
  output logic [3:0]             m_axi_arid_o,
  input  logic [`AXI_DATA_W-1:0] m_axi_rdata_i,
  input  logic                   m_axi_rvalid_i,
  output logic                   m_axi_rready_o,
  // serial output
  output logic [7:0]             uart_tx_data_o,
  output logic                   uart_tx_valid_o
);

  dev_wr_if uart_wr ();
  dev_rd_if clint_rd ();

  // core side and AXI ports share names with the arbiter
  bus_arbiter u_bus_arbiter (
    .uart_wr  (uart_wr.master),
    .clint_rd (clint_rd.master),
    .*
  );

  uart_tx_buffer u_uart_tx_buffer (
    .clk        (clk),
    .rst        (rst),
    .wr         (uart_wr.slave),
    .tx_data_o  (uart_tx_data_o),
    .tx_valid_o (uart_tx_valid_o)
  );

  clint_timer u_clint_timer (
    .clk (clk),
    .rst (rst),
    .rd  (clint_rd.slave)
  );

endmodule

// File: src/dev_bus_if.sv
`include "bus_cfg.svh"

// byte writes from the arbiter to a bus_pkg::DEV_SERIAL target
// a byte moves in any cycle with wvalid and wready both high
interface dev_wr_if;
  logic       wvalid;
  logic [7:0] wdata;
  logic       wready;

  modport master (
    output wvalid,
    output wdata,
    input  wready
  );

  modport slave (
    input  wvalid,
    input  wdata,
    output wready
  );
endinterface

// word reads from the arbiter to a bus_pkg::DEV_TIMER target
// arvalid is a single-cycle pulse, rvalid follows one cycle later
interface dev_rd_if;
  logic                   arvalid;
  logic                   sel_hi;
  logic [`BUS_DATA_W-1:0] rdata;
  logic                   rvalid;

  modport master (
    output arvalid,
    output sel_hi,
    input  rdata,
    input  rvalid
  );

  modport slave (
    input  arvalid,
    input  sel_hi,
    output rdata,
    output rvalid
  );
endinterface

// File: src/uart_tx_buffer.sv
`include "bus_cfg.svh"

module uart_tx_buffer (
  input  logic       clk,
  input  logic       rst,
  dev_wr_if.slave    wr,
  output logic [7:0] tx_data_o,
  output logic       tx_valid_o
);

  localparam int PTR_W   = $clog2(`UART_DEPTH);
  localparam int DRAIN_W = $clog2(`UART_DRAIN_CYCLES);

  logic [7:0]         mem [`UART_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W:0]     count;
  logic [DRAIN_W-1:0] drain_cnt;
  logic               push;
  logic               pop;

  assign wr.wready = (count != (PTR_W + 1)'(`UART_DEPTH));
  assign push      = wr.wvalid && wr.wready;
  // release on the last cycle of each drain period
  assign pop       = (count != '0) && (drain_cnt == DRAIN_W'(`UART_DRAIN_CYCLES - 1));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      drain_cnt  <= '0;
      tx_valid_o <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(`UART_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(`UART_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
      // counter idles at zero while empty
      if (count == '0)
        drain_cnt <= '0;
      else
        drain_cnt <= pop ? '0 : drain_cnt + 1'b1;
      tx_valid_o <= pop;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= wr.wdata;
    if (pop)
      tx_data_o <= mem[rd_ptr];
  end

  // a full buffer keeps its write pointer
  no_push_full: assert property (@(posedge clk) disable iff (rst)
    (count == (PTR_W + 1)'(`UART_DEPTH)) |=> $stable(wr_ptr));

endmodule

// File: verif/axi_mem_model.sv
`include "bus_cfg.svh"

// holds ready or valid off for 0 to 3 cycles after start
module random_delay (
  input  logic clk,
  input  logic rst,
  input  logic start_i,
  input  logic ack_i,
  output logic ready_o
);

  logic       armed;
  logic [1:0] dly;

  assign ready_o = armed && (dly == 2'd0);

  always @(posedge clk)
  begin
    if (rst)
    begin
      armed <= 1'b0;
      dly   <= 2'd0;
    end
    else if (ready_o && ack_i)
      armed <= 1'b0;
    else if (!armed && start_i)
    begin
      armed <= 1'b1;
      dly   <= 2'($urandom_range(3));
    end
    else if (dly != 2'd0)
      dly <= dly - 1'b1;
  end

endmodule

// single-beat AXI4 slave over a word array
module axi_mem_model (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`BUS_ADDR_W-1:0] awaddr_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  axi_pkg::size_e         awsize_i,
  input  logic [`AXI_DATA_W-1:0] wdata_i,
  input  logic [`AXI_STRB_W-1:0] wstrb_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  input  logic [`BUS_ADDR_W-1:0] araddr_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  output logic [`AXI_DATA_W-1:0] rdata_o,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  output axi_pkg::size_e         last_awsize_o,
  output int                     valid_cnt_o
);

  logic [31:0]            mem [256];
  logic                   aw_done;
  logic                   w_done;
  logic [`BUS_ADDR_W-1:0] wr_addr;
  logic [`BUS_ADDR_W-1:0] rd_addr;
  logic [31:0]            wr_data;
  logic [3:0]             wr_strb;

  // pattern built from the full word index
  initial
  begin
    for (int i = 0; i < 256; i++)
      mem[i] = 32'hd00d_0000 | (i << 2);
  end

  random_delay u_aw_dly (.clk(clk), .rst(rst), .start_i(awvalid_i), .ack_i(awvalid_i),
                         .ready_o(awready_o));
  random_delay u_w_dly (.clk(clk), .rst(rst), .start_i(wvalid_i), .ack_i(wvalid_i),
                        .ready_o(wready_o));
  random_delay u_b_dly (.clk(clk), .rst(rst), .start_i(aw_done && w_done), .ack_i(bready_i),
                        .ready_o(bvalid_o));
  random_delay u_ar_dly (.clk(clk), .rst(rst), .start_i(arvalid_i), .ack_i(arvalid_i),
                         .ready_o(arready_o));
  random_delay u_r_dly (.clk(clk), .rst(rst), .start_i(arvalid_i && arready_o),
                        .ack_i(rready_i), .ready_o(rvalid_o));

  assign rdata_o = {32'h0, mem[rd_addr[9:2]]};

  always @(posedge clk)
  begin
    if (rst)
    begin
      aw_done       <= 1'b0;
      w_done        <= 1'b0;
      valid_cnt_o   <= 0;
      last_awsize_o <= axi_pkg::SIZE_8B;
    end
    else
    begin
      if (awvalid_i || wvalid_i || arvalid_i)
        valid_cnt_o <= valid_cnt_o + 1;
      if (awvalid_i && awready_o)
      begin
        aw_done       <= 1'b1;
        wr_addr       <= awaddr_i;
        last_awsize_o <= awsize_i;
      end
      if (wvalid_i && wready_o)
      begin
        w_done  <= 1'b1;
        wr_data <= wdata_i[31:0];
        wr_strb <= wstrb_i[3:0];
      end
      // commit once both address and data have arrived
      if (aw_done && w_done)
      begin
        aw_done <= 1'b0;
        w_done  <= 1'b0;
        for (int b = 0; b < 4; b++)
          if (wr_strb[b])
            mem[wr_addr[9:2]][8*b +: 8] <= wr_data[8*b +: 8];
      end
      if (arvalid_i && arready_o)
        rd_addr <= araddr_i;
    end
  end

endmodule

// File: verif/tb_core_bus_top.sv
`include "bus_cfg.svh"

module tb_core_bus_top;

  localparam int TIMEOUT = 100;

  typedef enum logic [2:0] {OP_STORE, OP_FETCH, OP_LOAD, OP_DUAL, OP_TIMER} op_e;

  // addr_b and exp_b are the fetch side of a dual row
  typedef struct {
    op_e                    op;
    logic [`BUS_ADDR_W-1:0] addr;
    logic [`BUS_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    logic [`BUS_DATA_W-1:0] exp;
    logic [`BUS_ADDR_W-1:0] addr_b;
    logic [`BUS_DATA_W-1:0] exp_b;
  } row_t;

  logic                   clk;
  logic                   rst;
  logic                   ifu_arvalid_i;
  logic [`BUS_ADDR_W-1:0] ifu_araddr_i;
  logic [`BUS_DATA_W-1:0] ifu_rdata_o;
  logic                   ifu_rvalid_o;
  logic                   lsu_arvalid_i;
  logic [`BUS_ADDR_W-1:0] lsu_araddr_i;
  logic [`BUS_DATA_W-1:0] lsu_rdata_o;
  logic                   lsu_rvalid_o;
  logic                   lsu_awvalid_i;
  logic [`BUS_ADDR_W-1:0] lsu_awaddr_i;
  logic [`BUS_DATA_W-1:0] lsu_wdata_i;
  logic [`AXI_STRB_W-1:0] lsu_wstrb_i;
  logic                   lsu_wready_o;
  logic [`BUS_ADDR_W-1:0] m_axi_awaddr_o;
  logic                   m_axi_awvalid_o;
  logic                   m_axi_awready_i;
  logic [7:0]             m_axi_awlen_o;
  axi_pkg::size_e         m_axi_awsize_o;
  axi_pkg::burst_e        m_axi_awburst_o;
  logic [3:0]             m_axi_awid_o;
  logic [`AXI_DATA_W-1:0] m_axi_wdata_o;
  logic [`AXI_STRB_W-1:0] m_axi_wstrb_o;
  logic                   m_axi_wlast_o;
  logic                   m_axi_wvalid_o;
  logic                   m_axi_wready_i;
  logic                   m_axi_bvalid_i;
  logic                   m_axi_bready_o;
  logic [`BUS_ADDR_W-1:0] m_axi_araddr_o;
  logic                   m_axi_arvalid_o;
  logic                   m_axi_arready_i;
  logic [7:0]             m_axi_arlen_o;
  axi_pkg::size_e         m_axi_arsize_o;
  axi_pkg::burst_e        m_axi_arburst_o;
  logic [3:0]             m_axi_arid_o;
  logic [`AXI_DATA_W-1:0] m_axi_rdata_i;
  logic                   m_axi_rvalid_i;
  logic                   m_axi_rready_o;
  logic [7:0]             uart_tx_data_o;
  logic                   uart_tx_valid_o;

  axi_pkg::size_e         last_awsize;
  int                     valid_cnt;
  row_t                   stim_q[$];
  logic [7:0]             uart_exp_q[$];
  logic [7:0]             uart_exp_byte;
  logic [`BUS_DATA_W-1:0] last_time = '0;
  int                     ifu_pulses = 0;
  int                     errors = 0;
  int                     timeouts = 0;

  core_bus_top u_core_bus_top (.*);

  axi_mem_model u_axi_mem_model (
    .clk           (clk),
    .rst           (rst),
    .awaddr_i      (m_axi_awaddr_o),
    .awvalid_i     (m_axi_awvalid_o),
    .awready_o     (m_axi_awready_i),
    .awsize_i      (m_axi_awsize_o),
    .wdata_i       (m_axi_wdata_o),
    .wstrb_i       (m_axi_wstrb_o),
    .wvalid_i      (m_axi_wvalid_o),
    .wready_o      (m_axi_wready_i),
    .bvalid_o      (m_axi_bvalid_i),
    .bready_i      (m_axi_bready_o),
    .araddr_i      (m_axi_araddr_o),
    .arvalid_i     (m_axi_arvalid_o),
    .arready_o     (m_axi_arready_i),
    .rdata_o       (m_axi_rdata_i),
    .rvalid_o      (m_axi_rvalid_i),
    .rready_i      (m_axi_rready_o),
    .last_awsize_o (last_awsize),
    .valid_cnt_o   (valid_cnt)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // serial bytes must leave in store order
  always @(negedge clk)
  begin
    if (!rst && uart_tx_valid_o)
    begin
      if (uart_exp_q.size() == 0)
      begin
        $display("serial byte 0x%h came out with none pending", uart_tx_data_o);
        errors++;
      end
      else
      begin
        uart_exp_byte = uart_exp_q.pop_front();
        assert (uart_tx_data_o == uart_exp_byte)
        else
        begin
          $display("** Error: uart_tx_data_o = 0x%h, expected 0x%h", uart_tx_data_o,
                   uart_exp_byte);
          errors++;
        end
      end
    end
  end

  always @(negedge clk)
  begin
    if (ifu_rvalid_o)
      ifu_pulses++;
  end

  function automatic void add_row(op_e op, logic [31:0] addr, logic [31:0] data,
                                  logic [7:0] strb, logic [31:0] exp,
                                  logic [31:0] addr_b, logic [31:0] exp_b);
    row_t r;
    r = '{op, addr, data, strb, exp, addr_b, exp_b};
    stim_q.push_back(r);
  endfunction

  // one lane is a byte, two a half, four a word
  function automatic axi_pkg::size_e size_for_strb(logic [7:0] strb);
    case (strb)
      8'h01:   return axi_pkg::SIZE_1B;
      8'h03:   return axi_pkg::SIZE_2B;
      default: return axi_pkg::SIZE_4B;
    endcase
  endfunction

  function automatic bit is_device(logic [31:0] addr);
    return (addr == `BUS_SERIAL_ADDR) || (addr == `BUS_RTC_ADDR) || (addr == `BUS_RTC_ADDR_UP);
  endfunction

  function automatic bit pulse_high(int which);
    case (which)
      0:       return ifu_rvalid_o;
      1:       return lsu_rvalid_o;
      default: return lsu_wready_o;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp)
    else
    begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // single-beat INCR transfers with ID zero, responses always accepted
  always @(negedge clk)
  begin
    if (!rst && m_axi_awvalid_o)
    begin
      check_value("m_axi_awlen_o", m_axi_awlen_o, 32'h0);
      check_value("m_axi_awburst_o", m_axi_awburst_o, axi_pkg::BURST_INCR);
      check_value("m_axi_awid_o", m_axi_awid_o, 32'h0);
    end
    if (!rst && m_axi_wvalid_o)
      check_value("m_axi_wlast_o", m_axi_wlast_o, 32'h1);
    if (!rst && m_axi_arvalid_o)
    begin
      check_value("m_axi_arlen_o", m_axi_arlen_o, 32'h0);
      check_value("m_axi_arsize_o", m_axi_arsize_o, axi_pkg::SIZE_4B);
      check_value("m_axi_arburst_o", m_axi_arburst_o, axi_pkg::BURST_INCR);
      check_value("m_axi_arid_o", m_axi_arid_o, 32'h0);
    end
    if (!rst && m_axi_bvalid_i)
      check_value("m_axi_bready_o", m_axi_bready_o, 32'h1);
    if (!rst && m_axi_rvalid_i)
      check_value("m_axi_rready_o", m_axi_rready_o, 32'h1);
  end

  // lat counts cycles after the request cycle, -1 on timeout
  task automatic wait_pulse(input int which, output int lat);
    lat = 0;
    @(negedge clk);
    while (!pulse_high(which))
    begin
      if (lat == TIMEOUT)
      begin
        $display("timeout: no response pulse %0d from the DUT within %0d cycles", which, TIMEOUT);
        timeouts++;
        lat = -1;
        return;
      end
      lat++;
      @(negedge clk);
    end
  endtask

  task automatic release_requests();
    @(posedge clk);
    #1;
    ifu_arvalid_i = 1'b0;
    lsu_arvalid_i = 1'b0;
    lsu_awvalid_i = 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    int lat;
    int valids;
    int fetch_before;
    valids = valid_cnt;
    case (r.op)
      OP_STORE:
      begin
        lsu_awvalid_i = 1'b1;
        lsu_awaddr_i  = r.addr;
        lsu_wdata_i   = r.data;
        lsu_wstrb_i   = r.strb;
        if (r.addr == `BUS_SERIAL_ADDR)
          uart_exp_q.push_back(r.data[7:0]);
        wait_pulse(2, lat);
        if ((lat >= 0) && !is_device(r.addr))
          check_value("m_axi_awsize_o", last_awsize, size_for_strb(r.strb));
      end
      OP_FETCH:
      begin
        ifu_arvalid_i = 1'b1;
        ifu_araddr_i  = r.addr;
        wait_pulse(0, lat);
        if (lat >= 0)
          check_value("ifu_rdata_o", ifu_rdata_o, r.exp);
      end
      OP_DUAL:
      begin
        fetch_before  = ifu_pulses;
        lsu_arvalid_i = 1'b1;
        lsu_araddr_i  = r.addr;
        ifu_arvalid_i = 1'b1;
        ifu_araddr_i  = r.addr_b;
        wait_pulse(1, lat);
        if (lat >= 0)
        begin
          check_value("lsu_rdata_o", lsu_rdata_o, r.exp);
          assert (ifu_pulses == fetch_before)
          else
          begin
            $display("fetch was answered before the competing load");
            errors++;
          end
          @(posedge clk);
          #1;
          lsu_arvalid_i = 1'b0;
          wait_pulse(0, lat);
          if (lat >= 0)
            check_value("ifu_rdata_o", ifu_rdata_o, r.exp_b);
        end
      end
      default:
      begin
        lsu_arvalid_i = 1'b1;
        lsu_araddr_i  = r.addr;
        wait_pulse(1, lat);
        if ((lat >= 0) && (r.op == OP_LOAD))
          check_value("lsu_rdata_o", lsu_rdata_o, r.exp);
        else if (lat >= 0)
        begin
          check_value("lsu_rvalid_o latency", lat, 2);
          if (r.addr == `BUS_RTC_ADDR)
          begin
            assert (lsu_rdata_o > last_time)
            else
            begin
              $display("timer low word did not advance, still 0x%h", lsu_rdata_o);
              errors++;
            end
            last_time = lsu_rdata_o;
          end
          else
            check_value("lsu_rdata_o", lsu_rdata_o, r.exp);
        end
      end
    endcase
    release_requests();
    if (is_device(r.addr))
    begin
      assert (valid_cnt == valids)
      else
      begin
        $display("device access to 0x%h raised an AXI valid", r.addr);
        errors++;
      end
    end
  endtask

  initial
  begin
    int seed;
    int n;
    seed            = $urandom(60391);
    rst             = 1'b1;
    ifu_arvalid_i   = 1'b0;
    ifu_araddr_i    = '0;
    lsu_arvalid_i   = 1'b0;
    lsu_araddr_i    = '0;
    lsu_awvalid_i   = 1'b0;
    lsu_awaddr_i    = '0;
    lsu_wdata_i     = '0;
    lsu_wstrb_i     = '0;

    add_row(OP_STORE, 32'h0000_0100, 32'h1234_5678, 8'h0f, 32'h0, 32'h0, 32'h0);
    add_row(OP_FETCH, 32'h0000_0100, 32'h0, 8'h0, 32'h1234_5678, 32'h0, 32'h0);
    add_row(OP_LOAD, 32'h0000_0100, 32'h0, 8'h0, 32'h1234_5678, 32'h0, 32'h0);
    add_row(OP_STORE, 32'h0000_0104, 32'h0000_00a5, 8'h01, 32'h0, 32'h0, 32'h0);
    add_row(OP_STORE, 32'h0000_0104, 32'h0000_b00c, 8'h03, 32'h0, 32'h0, 32'h0);
    add_row(OP_STORE, 32'h0000_0108, 32'hcafe_f00d, 8'h0f, 32'h0, 32'h0, 32'h0);
    add_row(OP_DUAL, 32'h0000_0108, 32'h0, 8'h0, 32'hcafe_f00d, 32'h0000_0100, 32'h1234_5678);
    // stores outrun the drain until the buffer fills and stalls them
    for (int k = 0; k < 4 * `UART_DEPTH; k++)
      add_row(OP_STORE, `BUS_SERIAL_ADDR, 32'h5a5a_5a40 + k, 8'h01, 32'h0, 32'h0, 32'h0);
    add_row(OP_TIMER, `BUS_RTC_ADDR, 32'h0, 8'h0, 32'h0, 32'h0, 32'h0);
    add_row(OP_TIMER, `BUS_RTC_ADDR, 32'h0, 8'h0, 32'h0, 32'h0, 32'h0);
    add_row(OP_TIMER, `BUS_RTC_ADDR_UP, 32'h0, 8'h0, 32'h0, 32'h0, 32'h0);

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    assert (!ifu_rvalid_o && !lsu_rvalid_o && !lsu_wready_o && !uart_tx_valid_o &&
            !m_axi_awvalid_o && !m_axi_wvalid_o && !m_axi_arvalid_o)
    else
    begin
      $display("a valid or ready output is high after reset");
      errors++;
    end

    for (int i = 0; (i < stim_q.size()) && (timeouts == 0); i++)
    begin
      @(posedge clk);
      #1;
      apply_row(stim_q[i]);
    end

    // let the serial buffer empty
    n = 0;
    while ((uart_exp_q.size() != 0) && (timeouts == 0))
    begin
      if (n == TIMEOUT)
      begin
        $display("timeout: %0d serial bytes never came out", uart_exp_q.size());
        timeouts++;
      end
      else
      begin
        n++;
        @(negedge clk);
      end
    end

    $display("checks done with %0d errors and %0d timeouts", errors, timeouts);
    if ((errors == 0) && (timeouts == 0))
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule
